// ==== filelist.f ====
+incdir+verilog
verilog/datapathPkg.sv
verilog/busArbiter.sv
verilog/registerFile.sv
verilog/specialRegisters.sv
verilog/multiCycleAlu.sv
verilog/dataPath.sv
verif/dataPath_sva.sv
verif/dataPath_tb.sv

// ==== Makefile ====
VERILATOR = verilator
SIMFLAGS  = --binary --timing --assert -j 0
LINTFLAGS = --lint-only --timing -Wall
TOP       = dataPath_tb
FILELIST  = filelist.f
BUILD_DIR = obj_dir
PASS_MSG  = Simulation completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== verif/dataPath_testdata.txt ====
// columns: opcode operandA operandB expectedZlo expectedZhi, all hex
// opcodes: add 03 sub 05 and 09 or 0a shl 0c shr 0d mul 0f neg 11 not 12
03 00000005 00000007 0000000c 00000000
03 7fffffff 00000001 80000000 ffffffff
05 00000010 00000020 fffffff0 ffffffff
05 12345678 02040608 10305070 00000000
09 f0f0f0f0 ff00ff00 f000f000 ffffffff
0a 0f0f0000 00f000f0 0fff00f0 00000000
0c 00000003 00000004 00000030 00000000
0c 00000001 0000001f 80000000 ffffffff
0c 0000000f 00000024 000000f0 00000000
0d 80000000 00000004 08000000 00000000
0d ffff0000 00000010 0000ffff 00000000
11 00000000 00000001 ffffffff ffffffff
11 12345678 fffffff6 0000000a 00000000
12 00000000 0f0f0f0f f0f0f0f0 ffffffff
01 11111111 22222222 00000000 00000000
0f 00000003 00000004 0000000c 00000000
0f fffffffd 00000007 ffffffeb ffffffff
0f ffffffff ffffffff 00000001 00000000
0f 00010000 00010000 00000000 00000001
0f 7fffffff 7fffffff 00000001 3fffffff
0f 80000000 00000002 00000000 ffffffff
0f 12345678 00000000 00000000 00000000
0f 80000000 80000000 00000000 40000000

// ==== verif/dataPath_tb.sv ====
// dataPath_tb testbench with clock, reset, vector file reader, bus sequencing and result checks
`timescale 1ns/100ps
`default_nettype none

`include "datapath_config.svh"

module dataPath_tb;

    localparam int    ClockPeriod   = 20;
    localparam int    FinishTimeout = 4 * `DP_MUL_STEPS;  // cycles to wait for finished
    localparam        LfsrSeed      = 32'h8a00_cefa;
    localparam string VectorFile    = "verif/dataPath_testdata.txt";

    logic Clock, rst;
    logic RFout, PCout, IRout, RYout, RZLOout, RZHIout, MARout, RHIout, RLOout, MDRout;
    logic RFin, PCin, IRin, RYin, MARin, RHIin, RLOin, MDRin, Read, start;
    datapathPkg::regSelect RFSelect;
    datapathPkg::aluOpcode opSelect;
    datapathPkg::dataWord  Mdatain;
    datapathPkg::dataWord  busValue;
    logic                  busConflict;
    logic                  finished;

    int          errorCount   = 0;
    int          timeoutCount = 0;
    logic [31:0] lfsrState;

    dataPath dataPath_inst (.*);

    initial begin
        Clock = 1'b0;
        forever #(ClockPeriod / 2) Clock = ~Clock;
    end

    function automatic logic [31:0] nextLfsr(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};  // taps 32 22 2 1
    endfunction

    // one LFSR step per bit taken
    function automatic logic [31:0] randomBits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsrState = nextLfsr(lfsrState);
            value = {value[30:0], lfsrState[0]};
        end
        return value;
    endfunction

    function automatic datapathPkg::regSelect randomRegister();
        datapathPkg::regSelect r;
        r = datapathPkg::regSelect'(randomBits(`DP_SEL_WIDTH));
        if (r == '0) begin
            r = 4'd1;  // R0 is not a real destination
        end
        return r;
    endfunction

    task automatic compareValues(input string testName, input datapathPkg::dataWord expected,
                                 input datapathPkg::dataWord actual);
        if (expected !== actual) begin
            errorCount++;
            $display("error %s expected %h actual %h", testName, expected, actual);
        end
    endtask

    task automatic clearControls();
        {RFout, PCout, IRout, RYout, RZLOout, RZHIout, MARout, RHIout, RLOout, MDRout} = '0;
        {RFin, PCin, IRin, RYin, MARin, RHIin, RLOin, MDRin, Read, start} = '0;
        RFSelect = '0;
        opSelect = '0;
    endtask

    task automatic nextCycle();
        @(negedge Clock);
        clearControls();
    endtask

    // bus is combinational, sampled a quarter period after the drive
    task automatic sampleBus(output datapathPkg::dataWord value);
        #(ClockPeriod / 4);
        value = busValue;
    endtask

    task automatic loadMdr(input datapathPkg::dataWord value);
        nextCycle();
        Mdatain = value;
        Read    = 1'b1;
        MDRin   = 1'b1;
    endtask

    task automatic waitForFinish(input string testName, output int latency);
        logic done;
        done    = 1'b0;
        latency = 0;
        while (!done && latency < FinishTimeout) begin
            nextCycle();
            latency++;
            done = finished;
        end
        if (!done) begin
            timeoutCount++;
            $display("%s: the ALU never finished within %0d cycles", testName, FinishTimeout);
        end
    endtask

    task automatic readZ(input string testName, input datapathPkg::dataWord expLo,
                         input datapathPkg::dataWord expHi);
        datapathPkg::dataWord value;
        nextCycle();
        RZLOout = 1'b1;
        sampleBus(value);
        compareValues({testName, " zlo"}, expLo, value);
        nextCycle();
        RZHIout = 1'b1;
        sampleBus(value);
        compareValues({testName, " zhi"}, expHi, value);
    endtask

    // A goes to Y, B to a random register that drives the bus in the start cycle
    task automatic runAluCase(input string testName, input datapathPkg::aluOpcode op,
                              input datapathPkg::dataWord a, input datapathPkg::dataWord b,
                              input datapathPkg::dataWord expLo,
                              input datapathPkg::dataWord expHi);
        datapathPkg::regSelect dest;
        int                    latency;
        dest = randomRegister();
        loadMdr(a);
        nextCycle();
        MDRout = 1'b1;
        RYin   = 1'b1;
        loadMdr(b);
        nextCycle();
        MDRout   = 1'b1;
        RFin     = 1'b1;
        RFSelect = dest;
        nextCycle();
        RFout    = 1'b1;
        RFSelect = dest;
        opSelect = op;
        start    = 1'b1;
        waitForFinish(testName, latency);
        compareValues({testName, " latency"},
                      (op == datapathPkg::OpMul) ? `DP_MUL_STEPS + 1 : 1, latency);
        readZ(testName, expLo, expHi);
    endtask

    task automatic registerLoadPath();
        datapathPkg::dataWord  value, seen;
        datapathPkg::regSelect dest;
        for (int i = 0; i < 4; i++) begin
            value = randomBits(`DP_WIDTH);
            dest  = randomRegister();
            loadMdr(value);
            nextCycle();
            MDRout   = 1'b1;
            RFin     = 1'b1;
            RFSelect = dest;
            nextCycle();
            RFout    = 1'b1;
            RFSelect = dest;
            sampleBus(seen);
            compareValues($sformatf("register load R%0d", dest), value, seen);
        end
    endtask

    task automatic zeroRegisterRead();
        datapathPkg::dataWord seen;
        loadMdr(32'ha5a5_5a5a);
        nextCycle();
        MDRout = 1'b1;
        RFin   = 1'b1;  // write aimed at R0
        nextCycle();
        RFout = 1'b1;
        sampleBus(seen);
        compareValues("R0 reads zero", '0, seen);
    endtask

    task automatic aluVectors();
        int                    fd, count;
        string                 line;
        datapathPkg::aluOpcode op;
        datapathPkg::dataWord  a, b, expLo, expHi;
        count = 0;
        fd = $fopen(VectorFile, "r");
        if (fd == 0) begin
            errorCount++;
            $display("could not open the test vector file %s", VectorFile);
        end else begin
            while ($fgets(line, fd) != 0) begin
                if ($sscanf(line, "%h %h %h %h %h", op, a, b, expLo, expHi) == 5) begin
                    count++;
                    runAluCase($sformatf("vector %0d op %0h", count, op), op, a, b, expLo, expHi);
                end
            end
            $fclose(fd);
            if (count == 0) begin
                errorCount++;
                $display("the test vector file holds no vectors");
            end
        end
    endtask

    // second start lands two cycles into the multiply and must be dropped
    task automatic multiplyBackPressure();
        datapathPkg::dataWord  a, b;
        datapathPkg::regSelect dest;
        logic [63:0]           product;
        int                    latency, extraPulses;
        a       = 32'hffff_fff9;
        b       = 32'h0000_0123;
        product = 64'($signed(a)) * 64'($signed(b));
        dest    = randomRegister();
        loadMdr(a);
        nextCycle();
        MDRout = 1'b1;
        RYin   = 1'b1;
        loadMdr(b);
        nextCycle();
        MDRout   = 1'b1;
        RFin     = 1'b1;
        RFSelect = dest;
        nextCycle();
        RFout    = 1'b1;
        RFSelect = dest;
        opSelect = datapathPkg::OpMul;
        start    = 1'b1;
        nextCycle();
        nextCycle();
        MDRout   = 1'b1;
        opSelect = datapathPkg::OpAdd;
        start    = 1'b1;
        waitForFinish("back-pressure", latency);
        compareValues("back-pressure latency", `DP_MUL_STEPS - 1, latency);
        extraPulses = 0;
        repeat (2 * `DP_MUL_STEPS) begin
            nextCycle();
            if (finished) extraPulses++;
        end
        compareValues("back-pressure extra finished", 0, extraPulses);
        readZ("back-pressure", product[31:0], product[63:32]);
    endtask

    task automatic arbiterPriority();
        datapathPkg::dataWord pcWord, seen;
        pcWord = randomBits(`DP_WIDTH);
        loadMdr(pcWord);
        nextCycle();
        MDRout = 1'b1;
        PCin   = 1'b1;
        loadMdr(~pcWord);
        $assertoff;  // the conflict below is intended
        nextCycle();
        PCout  = 1'b1;
        MDRout = 1'b1;
        sampleBus(seen);
        compareValues("arbiter priority bus", pcWord, seen);
        compareValues("arbiter conflict flag", 32'd1, datapathPkg::dataWord'(busConflict));
        nextCycle();
        $asserton;
    endtask

    initial begin
        lfsrState = LfsrSeed;
        rst       = 1'b1;
        Mdatain   = '0;
        clearControls();
        repeat (4) @(negedge Clock);
        rst = 1'b0;
        compareValues("finished after reset", '0, datapathPkg::dataWord'(finished));
        readZ("after reset", '0, '0);
        registerLoadPath();
        zeroRegisterRead();
        aluVectors();
        multiplyBackPressure();
        arbiterPriority();
        $display("mismatches %0d, timeouts %0d", errorCount, timeoutCount);
        if (errorCount == 0 && timeoutCount == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/dataPath_sva.sv ====
// dataPath_sva checker with bus conflict, finished pulse and start ordering assertions, and its bind
`timescale 1ns/100ps
`default_nettype none

module dataPath_sva (
    input wire logic Clock,
    input wire logic rst,
    input wire logic start,
    input wire logic finished,
    input wire logic busConflict
);

    logic startSeen;  // set by a start, cleared again by the finished pulse that answers it

    always_ff @(posedge Clock) begin
        if (rst) begin
            startSeen <= 1'b0;
        end else if (finished) begin
            startSeen <= 1'b0;
        end else if (start) begin
            startSeen <= 1'b1;
        end
    end

    noBusConflict: assert property (@(posedge Clock) disable iff (rst) !busConflict)
        else $error("more than one source drove the bus");

    // finished is a single-cycle pulse
    finishedPulse: assert property (@(posedge Clock) disable iff (rst) finished |=> !finished)
        else $error("finished stayed high for two cycles");

    finishedAfterStart: assert property (@(posedge Clock) disable iff (rst)
        $rose(finished) |-> startSeen)
        else $error("finished rose without a start since the previous finished");

endmodule

bind dataPath dataPath_sva dataPath_sva_inst (
    .Clock       (Clock),
    .rst         (rst),
    .start       (start),
    .finished    (finished),
    .busConflict (busConflict)
);

`default_nettype wire

// ==== verilog/dataPath.sv ====
// dataPath top level joining the bus arbiter, register file, dedicated registers and ALU
`timescale 1ns/100ps
`default_nettype none

module dataPath (
    input  wire logic                  Clock,
    input  wire logic                  rst,
    input  wire logic                  RFout,
    input  wire logic                  PCout,
    input  wire logic                  IRout,
    input  wire logic                  RYout,
    input  wire logic                  RZLOout,
    input  wire logic                  RZHIout,
    input  wire logic                  MARout,
    input  wire logic                  RHIout,
    input  wire logic                  RLOout,
    input  wire logic                  MDRout,
    input  wire logic                  RFin,
    input  wire logic                  PCin,
    input  wire logic                  IRin,
    input  wire logic                  RYin,
    input  wire logic                  MARin,
    input  wire logic                  RHIin,
    input  wire logic                  RLOin,
    input  wire logic                  MDRin,
    input  wire logic                  Read,
    input  wire logic                  start,
    input  wire datapathPkg::regSelect RFSelect,
    input  wire datapathPkg::aluOpcode opSelect,
    input  wire datapathPkg::dataWord  Mdatain,
    output datapathPkg::dataWord       busValue,
    output logic                       busConflict,
    output logic                       finished
);

    datapathPkg::dataWord rfValue, pcValue, irValue, yValue, zLoValue, zHiValue;
    datapathPkg::dataWord marValue, hiValue, loValue, mdrValue;

    busArbiter busArbiter_inst (
        .request     ({RFout, PCout, IRout, RYout, RZLOout, RZHIout,
                       MARout, RHIout, RLOout, MDRout}),  // priority order
        .rfValue     (rfValue),
        .pcValue     (pcValue),
        .irValue     (irValue),
        .yValue      (yValue),
        .zLoValue    (zLoValue),
        .zHiValue    (zHiValue),
        .marValue    (marValue),
        .hiValue     (hiValue),
        .loValue     (loValue),
        .mdrValue    (mdrValue),
        .busValue    (busValue),
        .busConflict (busConflict)
    );

    registerFile registerFile_inst (
        .Clock    (Clock),
        .rst      (rst),
        .RFSelect (RFSelect),
        .RFin     (RFin),
        .busValue (busValue),
        .rfValue  (rfValue)
    );

    specialRegisters specialRegisters_inst (
        .Clock    (Clock),
        .rst      (rst),
        .busValue (busValue),
        .Mdatain  (Mdatain),
        .PCin     (PCin),
        .IRin     (IRin),
        .MARin    (MARin),
        .RHIin    (RHIin),
        .RLOin    (RLOin),
        .RYin     (RYin),
        .MDRin    (MDRin),
        .Read     (Read),
        .pcValue  (pcValue),
        .irValue  (irValue),
        .marValue (marValue),
        .hiValue  (hiValue),
        .loValue  (loValue),
        .yValue   (yValue),
        .mdrValue (mdrValue)
    );

    multiCycleAlu multiCycleAlu_inst (
        .Clock    (Clock),
        .rst      (rst),
        .start    (start),
        .opSelect (opSelect),
        .yValue   (yValue),    // A operand
        .busValue (busValue),  // B operand
        .finished (finished),
        .zLoValue (zLoValue),
        .zHiValue (zHiValue)
    );

endmodule

`default_nettype wire

// ==== verilog/multiCycleAlu.sv ====
// multiCycleAlu module with the ALU FSM, single-cycle operations, shift-add multiply and Z
`timescale 1ns/100ps
`default_nettype none

`include "datapath_config.svh"

module multiCycleAlu (
    input  wire logic                  Clock,
    input  wire logic                  rst,
    input  wire logic                  start,
    input  wire datapathPkg::aluOpcode opSelect,
    input  wire datapathPkg::dataWord  yValue,
    input  wire datapathPkg::dataWord  busValue,
    output logic                       finished,
    output datapathPkg::dataWord       zLoValue,
    output datapathPkg::dataWord       zHiValue
);

    datapathPkg::aluState state;
    logic [5:0]           stepCount;
    datapathPkg::dataWord result;      // single-cycle result
    datapathPkg::dataWord mcand;       // multiplicand magnitude
    logic [2*`DP_WIDTH-1:0] prod;      // partial product over multiplier
    logic [2*`DP_WIDTH-1:0] prodNext;
    logic [2*`DP_WIDTH-1:0] product;   // sign-corrected final product
    logic [`DP_WIDTH:0]   stepSum;     // upper half plus carry
    logic                 negProduct;
    logic                 mulStart;

    assign mulStart = (state == datapathPkg::Idle) && start && (opSelect == datapathPkg::OpMul);

    always_comb begin
        case (opSelect)
            datapathPkg::OpAdd: result = yValue + busValue;
            datapathPkg::OpSub: result = yValue - busValue;
            datapathPkg::OpAnd: result = yValue & busValue;
            datapathPkg::OpOr:  result = yValue | busValue;
            datapathPkg::OpShl: result = yValue << busValue[4:0];
            datapathPkg::OpShr: result = yValue >> busValue[4:0];  // logical shift
            datapathPkg::OpNeg: result = -busValue;
            datapathPkg::OpNot: result = ~busValue;
            default:            result = '0;
        endcase
    end

    // one multiply step: add multiplicand if the low bit is set, then shift right
    assign stepSum  = {1'b0, prod[2*`DP_WIDTH-1:`DP_WIDTH]} +
                      (prod[0] ? {1'b0, mcand} : {(`DP_WIDTH+1){1'b0}});
    assign prodNext = {stepSum, prod[`DP_WIDTH-1:1]};
    assign product  = negProduct ? -prodNext : prodNext;

    always_ff @(posedge Clock) begin
        if (rst) begin
            state     <= datapathPkg::Idle;
            stepCount <= '0;
            zLoValue  <= '0;
            zHiValue  <= '0;
        end else begin
            case (state)
                datapathPkg::Idle: begin
                    if (mulStart) begin
                        state     <= datapathPkg::Multiply;
                        stepCount <= '0;
                    end else if (start) begin
                        zLoValue <= result;
                        zHiValue <= {`DP_WIDTH{result[`DP_WIDTH-1]}};  // sign extension
                        state    <= datapathPkg::Done;
                    end
                end
                datapathPkg::Multiply: begin
                    stepCount <= stepCount + 6'd1;
                    if (stepCount == 6'(`DP_MUL_STEPS - 1)) begin
                        zLoValue <= product[`DP_WIDTH-1:0];
                        zHiValue <= product[2*`DP_WIDTH-1:`DP_WIDTH];
                        state    <= datapathPkg::Done;
                    end
                end
                default: state <= datapathPkg::Idle;  // Done lasts one cycle
            endcase
        end
    end

    // operands reduced to magnitudes, the sign is put back at the end
    always_ff @(posedge Clock) begin
        if (mulStart) begin
            mcand      <= yValue[`DP_WIDTH-1] ? -yValue : yValue;
            prod       <= {{`DP_WIDTH{1'b0}}, busValue[`DP_WIDTH-1] ? -busValue : busValue};
            negProduct <= yValue[`DP_WIDTH-1] ^ busValue[`DP_WIDTH-1];
        end else if (state == datapathPkg::Multiply) begin
            prod <= prodNext;
        end
    end

    assign finished = (state == datapathPkg::Done);  // one-cycle pulse

endmodule

`default_nettype wire

// ==== verilog/specialRegisters.sv ====
// specialRegisters module holding PC, IR, MAR, MDR, HI, LO and Y with their load enables
`timescale 1ns/100ps
`default_nettype none

module specialRegisters (
    input  wire logic                 Clock,
    input  wire logic                 rst,
    input  wire datapathPkg::dataWord busValue,
    input  wire datapathPkg::dataWord Mdatain,
    input  wire logic                 PCin,
    input  wire logic                 IRin,
    input  wire logic                 MARin,
    input  wire logic                 RHIin,
    input  wire logic                 RLOin,
    input  wire logic                 RYin,
    input  wire logic                 MDRin,
    input  wire logic                 Read,
    output datapathPkg::dataWord      pcValue,
    output datapathPkg::dataWord      irValue,
    output datapathPkg::dataWord      marValue,
    output datapathPkg::dataWord      hiValue,
    output datapathPkg::dataWord      loValue,
    output datapathPkg::dataWord      yValue,
    output datapathPkg::dataWord      mdrValue
);

    always_ff @(posedge Clock) begin
        if (rst) begin
            pcValue  <= '0;
            irValue  <= '0;
            marValue <= '0;
            hiValue  <= '0;
            loValue  <= '0;
            yValue   <= '0;
        end else begin
            if (PCin)  pcValue  <= busValue;
            if (IRin)  irValue  <= busValue;
            if (MARin) marValue <= busValue;
            if (RHIin) hiValue  <= busValue;
            if (RLOin) loValue  <= busValue;
            if (RYin)  yValue   <= busValue;  // ALU A operand
        end
    end

    // memory data register, fed from memory during a read and from the bus otherwise
    always_ff @(posedge Clock) begin
        if (rst) begin
            mdrValue <= '0;
        end else if (MDRin) begin
            mdrValue <= Read ? Mdatain : busValue;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/registerFile.sv ====
// registerFile module with sixteen bus-loaded registers and a hardwired zero R0
`timescale 1ns/100ps
`default_nettype none

`include "datapath_config.svh"

module registerFile (
    input  wire logic                  Clock,
    input  wire logic                  rst,
    input  wire datapathPkg::regSelect RFSelect,
    input  wire logic                  RFin,
    input  wire datapathPkg::dataWord  busValue,
    output datapathPkg::dataWord       rfValue
);

    datapathPkg::dataWord regs [`DP_NUM_REGS];

    always_ff @(posedge Clock) begin
        if (rst) begin
            for (int i = 0; i < `DP_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (RFin && (RFSelect != '0)) begin  // R0 writes dropped
            regs[RFSelect] <= busValue;
        end
    end

    // R0 gives a constant zero operand
    assign rfValue = (RFSelect == '0) ? '0 : regs[RFSelect];

endmodule

`default_nettype wire

// ==== verilog/busArbiter.sv ====
// busArbiter module with fixed-priority source selection, the bus mux and conflict detection
`timescale 1ns/100ps
`default_nettype none

module busArbiter (
    input  wire datapathPkg::sourceMask request,
    input  wire datapathPkg::dataWord   rfValue,
    input  wire datapathPkg::dataWord   pcValue,
    input  wire datapathPkg::dataWord   irValue,
    input  wire datapathPkg::dataWord   yValue,
    input  wire datapathPkg::dataWord   zLoValue,
    input  wire datapathPkg::dataWord   zHiValue,
    input  wire datapathPkg::dataWord   marValue,
    input  wire datapathPkg::dataWord   hiValue,
    input  wire datapathPkg::dataWord   loValue,
    input  wire datapathPkg::dataWord   mdrValue,
    output datapathPkg::dataWord        busValue,
    output logic                        busConflict
);

    // highest requested bit wins, RF at the top and MDR at the bottom
    always_comb begin
        if (request[9]) begin
            busValue = rfValue;
        end else if (request[8]) begin
            busValue = pcValue;
        end else if (request[7]) begin
            busValue = irValue;
        end else if (request[6]) begin
            busValue = yValue;
        end else if (request[5]) begin
            busValue = zLoValue;
        end else if (request[4]) begin
            busValue = zHiValue;
        end else if (request[3]) begin
            busValue = marValue;
        end else if (request[2]) begin
            busValue = hiValue;
        end else if (request[1]) begin
            busValue = loValue;
        end else if (request[0]) begin
            busValue = mdrValue;
        end else begin
            busValue = '0;  // idle bus reads zero
        end
    end

    // clearing the lowest set bit leaves something only if two or more were set
    assign busConflict = |(request & (request - datapathPkg::sourceMask'(1)));

endmodule

`default_nettype wire

// ==== verilog/datapathPkg.sv ====
// datapath package with word, select, opcode and bus-source types, opcodes and the ALU state enum
`default_nettype none

`include "datapath_config.svh"

package datapathPkg;

    typedef logic [`DP_WIDTH-1:0]       dataWord;    // one bus value
    typedef logic [`DP_SEL_WIDTH-1:0]   regSelect;   // register file index
    typedef logic [`DP_OP_WIDTH-1:0]    aluOpcode;
    typedef logic [`DP_NUM_SOURCES-1:0] sourceMask;  // bit 9 is RF, bit 0 is MDR

    // operation codes understood by the ALU, anything else yields zero
    localparam aluOpcode OpAdd = 5'd3;
    localparam aluOpcode OpSub = 5'd5;
    localparam aluOpcode OpAnd = 5'd9;
    localparam aluOpcode OpOr  = 5'd10;
    localparam aluOpcode OpShl = 5'd12;
    localparam aluOpcode OpShr = 5'd13;
    localparam aluOpcode OpMul = 5'd15;
    localparam aluOpcode OpNeg = 5'd17;
    localparam aluOpcode OpNot = 5'd18;

    typedef enum logic [1:0] {
        Idle,      // waiting for start
        Multiply,  // shift-add loop running
        Done       // Z written, finished high
    } aluState;

endpackage

`default_nettype wire

// ==== verilog/datapath_config.svh ====
// datapath width, register-file size, opcode width, bus source count and multiply length macros
`ifndef DATAPATH_CONFIG_SVH
`define DATAPATH_CONFIG_SVH

// word width of the bus and of every register
`define DP_WIDTH 32

// register file depth and the select width that indexes it
`define DP_NUM_REGS 16
`define DP_SEL_WIDTH 4

// ALU operation code width
`define DP_OP_WIDTH 5

// peers that can drive the shared bus
`define DP_NUM_SOURCES 10

`define DP_MUL_STEPS 32  // one shift-add step per multiplier bit

`endif
